/* hw/rvPkg.sv */
package rvPkg;

    // data words, word-form results and register numbers.
    typedef logic [63:0] u64;
    typedef logic [31:0] u32;
    typedef logic [4:0]  u5;

    // integer ALU operations.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } aluOp_t;

    // multiply and divide operations of the M extension.
    typedef enum logic [2:0] {
        MD_MUL    = 3'd0,
        MD_MULH   = 3'd1,
        MD_MULHSU = 3'd2,
        MD_MULHU  = 3'd3,
        MD_DIV    = 3'd4,
        MD_DIVU   = 3'd5,
        MD_REM    = 3'd6,
        MD_REMU   = 3'd7
    } mulOp_t;

    // CSR operations, the immediate forms take the zero-extended uimm from imm.
    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,
        CSRRW    = 3'd1,
        CSRRS    = 3'd2,
        CSRRC    = 3'd3,
        CSRRWI   = 3'd4,
        CSRRSI   = 3'd5,
        CSRRCI   = 3'd6
    } csrOp_t;

    // operand A source.
    typedef enum logic [1:0] {
        SRCA_ZERO    = 2'd0,
        SRCA_RS1     = 2'd1,
        SRCA_PC      = 2'd2,
        SRCA_PCPLUS4 = 2'd3
    } srcA_t;

    // operand B source, IMMUPPER is the immediate shifted left by 12.
    typedef enum logic [1:0] {
        SRCB_RS2      = 2'd0,
        SRCB_IMM      = 2'd1,
        SRCB_IMMUPPER = 2'd2,
        SRCB_CSR      = 2'd3
    } srcB_t;

    // comparison flag selection.
    typedef enum logic [1:0] {
        FLAG_LT  = 2'd0,
        FLAG_LTU = 2'd1,
        FLAG_EQ  = 2'd2
    } flagSel_t;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import rvPkg::*; #(
    parameter int XLEN = 64
) (
    input  u64     a,
    input  u64     b,
    input  aluOp_t op,
    output u64     result,
    output u32     resultWord
);

    localparam int ShW = $clog2(XLEN);

    logic [ShW-1:0] shamt;
    logic [4:0]     shamtWord;
    u32             aWord;
    u32             bWord;

    assign shamt     = b[ShW-1:0];
    assign shamtWord = b[4:0];
    assign aWord     = a[31:0];
    assign bWord     = b[31:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {63'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {63'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // word forms work on the low operand word only, so a word shift
    // never pulls in bits from the upper half.
    always_comb begin
        case (op)
            ALU_ADD: resultWord = aWord + bWord;
            ALU_SUB: resultWord = aWord - bWord;
            ALU_SLL: resultWord = aWord << shamtWord;
            ALU_SRL: resultWord = aWord >> shamtWord;
            ALU_SRA: resultWord = $signed(aWord) >>> shamtWord;
            default: resultWord = result[31:0];
        endcase
    end

endmodule

/* hw/mulDivPrep.sv */
`timescale 1ns/1ps

module mulDivPrep import rvPkg::*; #(
    parameter int XLEN = 64
) (
    input  u64     a,
    input  u64     b,
    input  mulOp_t op,
    output u64     magA,
    output u64     magB,
    output logic   isDiv,
    output logic   wantHigh,
    output logic   negate
);

    logic signedA;
    logic signedB;
    logic negA;
    logic negB;
    logic isRem;

    always_comb begin
        signedA  = 1'b0;
        signedB  = 1'b0;
        isDiv    = 1'b0;
        wantHigh = 1'b0;
        isRem    = 1'b0;
        case (op)
            MD_MUL:    ;
            MD_MULH:   begin signedA = 1'b1; signedB = 1'b1; wantHigh = 1'b1; end
            MD_MULHSU: begin signedA = 1'b1; wantHigh = 1'b1; end
            MD_MULHU:  wantHigh = 1'b1;
            MD_DIV:    begin signedA = 1'b1; signedB = 1'b1; isDiv = 1'b1; end
            MD_DIVU:   isDiv = 1'b1;
            MD_REM:    begin
                signedA = 1'b1;
                signedB = 1'b1;
                isDiv = 1'b1;
                wantHigh = 1'b1;
                isRem = 1'b1;
            end
            MD_REMU:   begin isDiv = 1'b1; wantHigh = 1'b1; isRem = 1'b1; end
            default:   ;
        endcase
    end

    assign negA = signedA & a[XLEN-1];
    assign negB = signedB & b[XLEN-1];

    assign magA = negA ? -a : a;
    assign magB = negB ? -b : b;

    // the remainder follows the dividend sign, everything else the sign of the product.
    assign negate = isRem ? negA : (negA ^ negB);

endmodule

/* hw/mulDivCore.sv */
`timescale 1ns/1ps

module mulDivCore import rvPkg::*; #(
    parameter int XLEN = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic start,
    input  logic isDiv,
    input  logic wantHigh,
    input  u64   magA,
    input  u64   magB,
    output logic done,
    output logic divZero,
    output u64   rawResult
);

    localparam int CntW = $clog2(XLEN);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t            state;
    logic [CntW-1:0]   count;
    logic              divMode;
    logic              highMode;
    logic              zeroDiv;

    // the accumulator holds {upper, lower}. For multiply the upper half collects
    // the partial sums while the multiplier shifts out of the lower half. For
    // divide the upper half is the partial remainder and the lower half turns
    // from dividend into quotient.
    logic [2*XLEN-1:0] acc;
    logic [2*XLEN-1:0] accNext;
    u64                operand;

    logic [XLEN:0]     sum;
    logic [XLEN:0]     window;
    logic [XLEN:0]     diff;
    logic              fits;

    always_comb begin
        sum    = {1'b0, acc[2*XLEN-1:XLEN]} + {1'b0, operand};
        window = acc[2*XLEN-1:XLEN-1];
        diff   = window - {1'b0, operand};
        fits   = window >= {1'b0, operand};
        if (divMode) begin
            if (fits) begin
                accNext = {diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
            end else begin
                accNext = {window[XLEN-1:0], acc[XLEN-2:0], 1'b0};
            end
        end else begin
            if (acc[0]) begin
                accNext = {sum, acc[XLEN-1:1]};
            end else begin
                accNext = {1'b0, acc[2*XLEN-1:XLEN], acc[XLEN-1:1]};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            count    <= '0;
            divMode  <= 1'b0;
            highMode <= 1'b0;
            zeroDiv  <= 1'b0;
        end else if (clear) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        count    <= '0;
                        divMode  <= isDiv;
                        highMode <= wantHigh;
                        zeroDiv  <= isDiv & (magB == '0);
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (count == CntW'(XLEN - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= DONE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            acc     <= {{XLEN{1'b0}}, magA};
            operand <= magB;
        end else if (state == RUN) begin
            acc <= accNext;
        end
    end

    // both units end with the wanted value in the same half of the accumulator.
    assign rawResult = highMode ? acc[2*XLEN-1:XLEN] : acc[XLEN-1:0];
    assign done      = state == DONE;
    assign divZero   = zeroDiv;

endmodule

/* hw/execute.sv */
`timescale 1ns/1ps

module execute import rvPkg::*; #(
    parameter int XLEN = 64
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  u64       rs1,
    input  u64       rs2,
    input  u64       imm,
    input  u64       pc,
    input  u64       pcPlus4,
    input  u64       csrValue,
    input  srcA_t    srcA,
    input  srcB_t    srcB,
    input  aluOp_t   aluOp,
    input  logic     isMul,
    input  mulOp_t   mulOp,
    input  logic     isWord,
    input  logic     isCond,
    input  flagSel_t useFlag,
    input  logic     flagInv,
    input  logic     cmpUseImm,
    input  csrOp_t   csrOp,
    input  u5        rd,
    input  logic     writeBack,
    input  logic     advance,
    input  logic     flush,
    output logic     stageReady,
    output logic     fwdValid,
    output u5        fwdRd,
    output u64       fwdData,
    output logic     outValid,
    output u64       outResult,
    output logic     outFlag,
    output u64       outCsrValue,
    output u5        outRd,
    output logic     outWriteBack
);

    u64   opA;
    u64   opB;
    u64   cmpB;
    u64   aluResult;
    u32   aluWord;
    u64   magA;
    u64   magB;
    u64   rawResult;
    u64   mulFixed;
    u64   csrWrite;
    u64   result;
    logic isDiv;
    logic wantHigh;
    logic negate;
    logic done;
    logic divZero;
    logic start;
    logic issued;
    logic lowProdZero;
    logic flag;

    function automatic int trailingZeros(input u64 v);
        int n;
        n = XLEN;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (v[i]) begin
                n = i;
            end
        end
        return n;
    endfunction

    always_comb begin
        case (srcA)
            SRCA_ZERO: opA = '0;
            SRCA_RS1:  opA = rs1;
            SRCA_PC:   opA = pc;
            default:   opA = pcPlus4;
        endcase
        case (srcB)
            SRCB_RS2:      opB = rs2;
            SRCB_IMM:      opB = imm;
            SRCB_IMMUPPER: opB = imm << 12;
            default:       opB = csrValue;
        endcase
    end

    assign cmpB = cmpUseImm ? imm : rs2;

    always_comb begin
        case (useFlag)
            FLAG_LT:  flag = $signed(rs1) < $signed(cmpB);
            FLAG_LTU: flag = rs1 < cmpB;
            default:  flag = rs1 == cmpB;
        endcase
        flag = flag ^ flagInv;
    end

    always_comb begin
        case (csrOp)
            CSRRW:   csrWrite = rs1;
            CSRRS:   csrWrite = csrValue | rs1;
            CSRRC:   csrWrite = csrValue & ~rs1;
            CSRRWI:  csrWrite = imm;
            CSRRSI:  csrWrite = csrValue | imm;
            CSRRCI:  csrWrite = csrValue & ~imm;
            default: csrWrite = csrValue;
        endcase
    end

    alu #(.XLEN(XLEN)) u_alu (
        .a(opA), .b(opB), .op(aluOp), .result(aluResult), .resultWord(aluWord)
    );

    mulDivPrep #(.XLEN(XLEN)) u_prep (
        .a(opA), .b(opB), .op(mulOp), .magA(magA), .magB(magB),
        .isDiv(isDiv), .wantHigh(wantHigh), .negate(negate)
    );

    mulDivCore #(.XLEN(XLEN)) u_core (
        .clk(clk), .rst(rst), .clear(advance), .start(start),
        .isDiv(isDiv), .wantHigh(wantHigh), .magA(magA), .magB(magB),
        .done(done), .divZero(divZero), .rawResult(rawResult)
    );

    assign start = inValid & isMul & ~issued;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issued <= 1'b0;
        end else if (advance) begin
            issued <= 1'b0;
        end else if (start) begin
            issued <= 1'b1;
        end
    end

    // negating the high product half needs a carry out of the low half,
    // which only happens when the whole low half of the product is zero.
    assign lowProdZero = (trailingZeros(magA) + trailingZeros(magB)) >= XLEN;

    // a quotient by zero stays all ones. The remainder still takes the dividend sign.
    always_comb begin
        if (!negate || (divZero && !wantHigh)) begin
            mulFixed = rawResult;
        end else if (wantHigh && !isDiv) begin
            mulFixed = ~rawResult + {63'b0, lowProdZero};
        end else begin
            mulFixed = -rawResult;
        end
    end

    always_comb begin
        if (isMul) begin
            result = isWord ? {{32{mulFixed[31]}}, mulFixed[31:0]} : mulFixed;
        end else if (isWord) begin
            result = {{32{aluWord[31]}}, aluWord};
        end else if (isCond) begin
            result = {63'b0, flag};
        end else begin
            result = aluResult;
        end
    end

    assign stageReady = ~inValid | ~isMul | done;
    assign fwdValid   = inValid & (rd != '0);
    assign fwdRd      = rd;
    assign fwdData    = result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid     <= 1'b0;
            outWriteBack <= 1'b0;
        end else if (advance) begin
            outValid     <= inValid & ~flush;
            outWriteBack <= writeBack;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            outResult   <= result;
            outFlag     <= flag;
            outCsrValue <= csrWrite;
            outRd       <= rd;
        end
    end

endmodule

/* tests/tbExecute.sv */
`timescale 1ns/1ps

module tbExecute import rvPkg::*; ();

    localparam int XLEN = 64;
    localparam int MaxVec = 128;
    localparam int NumRandom = 24;
    localparam u64 A0 = 64'h1234_5678_9abc_def0;
    localparam u64 B0 = 64'h0fed_cba9_8765_4321;
    localparam u64 AllOnes = 64'hffff_ffff_ffff_ffff;
    localparam u64 MinInt = 64'h8000_0000_0000_0000;
    localparam u64 Neg7 = 64'hffff_ffff_ffff_fff9;
    localparam u64 PcValue = 64'h0000_0000_8000_1000;
    localparam u64 CsrInit = 64'h0000_0000_f0f0_00ea;

    logic     clk;
    logic     rst;
    logic     inValid;
    u64       rs1;
    u64       rs2;
    u64       imm;
    u64       pc;
    u64       pcPlus4;
    u64       csrValue;
    srcA_t    srcA;
    srcB_t    srcB;
    aluOp_t   aluOp;
    logic     isMul;
    mulOp_t   mulOp;
    logic     isWord;
    logic     isCond;
    flagSel_t useFlag;
    logic     flagInv;
    logic     cmpUseImm;
    csrOp_t   csrOp;
    u5        rd;
    logic     writeBack;
    logic     advance;
    logic     flush;
    logic     stageReady;
    logic     fwdValid;
    u5        fwdRd;
    u64       fwdData;
    logic     outValid;
    u64       outResult;
    logic     outFlag;
    u64       outCsrValue;
    u5        outRd;
    logic     outWriteBack;

    // the vector table, one entry per instruction.
    string    vName[MaxVec];
    srcA_t    vSrcA[MaxVec];
    srcB_t    vSrcB[MaxVec];
    aluOp_t   vAluOp[MaxVec];
    logic     vIsMul[MaxVec];
    mulOp_t   vMulOp[MaxVec];
    logic     vIsWord[MaxVec];
    logic     vIsCond[MaxVec];
    flagSel_t vFlagSel[MaxVec];
    logic     vFlagInv[MaxVec];
    logic     vCmpImm[MaxVec];
    csrOp_t   vCsrOp[MaxVec];
    u64       vRs1[MaxVec];
    u64       vRs2[MaxVec];
    u64       vImm[MaxVec];
    u64       vExpResult[MaxVec];
    u64       vExpCsr[MaxVec];
    logic     vChkCsr[MaxVec];
    int       vExpFlag[MaxVec];
    logic     vFlush[MaxVec];
    int       nVec = 0;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'h32cb_e721;

    execute #(.XLEN(XLEN)) u_dut (
        .clk(clk), .rst(rst), .inValid(inValid), .rs1(rs1), .rs2(rs2), .imm(imm),
        .pc(pc), .pcPlus4(pcPlus4), .csrValue(csrValue), .srcA(srcA), .srcB(srcB),
        .aluOp(aluOp), .isMul(isMul), .mulOp(mulOp), .isWord(isWord), .isCond(isCond),
        .useFlag(useFlag), .flagInv(flagInv), .cmpUseImm(cmpUseImm), .csrOp(csrOp),
        .rd(rd), .writeBack(writeBack), .advance(advance), .flush(flush),
        .stageReady(stageReady), .fwdValid(fwdValid), .fwdRd(fwdRd), .fwdData(fwdData),
        .outValid(outValid), .outResult(outResult), .outFlag(outFlag),
        .outCsrValue(outCsrValue), .outRd(outRd), .outWriteBack(outWriteBack)
    );

    // a lone execute stage advances whenever it is ready.
    assign advance = stageReady;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input u64 expected, input u64 actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomBits(input int width, output u64 v);
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    // results of the M extension, with the RISC-V rules for division by zero and overflow.
    function automatic u64 mulDivModel(input mulOp_t op, input u64 a, input u64 b);
        logic [127:0]       prod;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        u64                 r;
        sa = a;
        sb = b;
        prod = '0;
        case (op)
            MD_MUL: begin
                prod = {64'b0, a} * {64'b0, b};
                r = prod[63:0];
            end
            MD_MULH: begin
                prod = {{64{a[63]}}, a} * {{64{b[63]}}, b};
                r = prod[127:64];
            end
            MD_MULHSU: begin
                prod = {{64{a[63]}}, a} * {64'b0, b};
                r = prod[127:64];
            end
            MD_MULHU: begin
                prod = {64'b0, a} * {64'b0, b};
                r = prod[127:64];
            end
            MD_DIV: begin
                if (b == 0) begin
                    r = AllOnes;
                end else if (a == MinInt && b == AllOnes) begin
                    r = a;
                end else begin
                    r = sa / sb;
                end
            end
            MD_DIVU: r = (b == 0) ? AllOnes : a / b;
            MD_REM: begin
                if (b == 0) begin
                    r = a;
                end else if (a == MinInt && b == AllOnes) begin
                    r = 64'd0;
                end else begin
                    r = sa % sb;
                end
            end
            default: r = (b == 0) ? a : a % b;
        endcase
        return r;
    endfunction

    task automatic addVec(input string name, input srcA_t sa, input srcB_t sb,
                          input aluOp_t op, input logic word, input u64 a, input u64 b,
                          input u64 i, input u64 expR);
        vName[nVec] = name;
        vSrcA[nVec] = sa;
        vSrcB[nVec] = sb;
        vAluOp[nVec] = op;
        vIsWord[nVec] = word;
        vRs1[nVec] = a;
        vRs2[nVec] = b;
        vImm[nVec] = i;
        vExpResult[nVec] = expR;
        vIsMul[nVec] = 1'b0;
        vMulOp[nVec] = MD_MUL;
        vIsCond[nVec] = 1'b0;
        vFlagSel[nVec] = FLAG_LT;
        vFlagInv[nVec] = 1'b0;
        vCmpImm[nVec] = 1'b0;
        vCsrOp[nVec] = CSR_NONE;
        vExpCsr[nVec] = '0;
        vChkCsr[nVec] = 1'b0;
        vExpFlag[nVec] = -1;
        vFlush[nVec] = 1'b0;
        nVec++;
    endtask

    // the helpers below refine the entry added last.
    task automatic setCond(input flagSel_t sel, input logic inv, input logic useImm,
                           input logic cond, input int expFlag);
        vFlagSel[nVec-1] = sel;
        vFlagInv[nVec-1] = inv;
        vCmpImm[nVec-1] = useImm;
        vIsCond[nVec-1] = cond;
        vExpFlag[nVec-1] = expFlag;
    endtask

    task automatic setMul(input mulOp_t op);
        vIsMul[nVec-1] = 1'b1;
        vMulOp[nVec-1] = op;
    endtask

    task automatic setCsr(input csrOp_t op, input u64 expCsr);
        vCsrOp[nVec-1] = op;
        vExpCsr[nVec-1] = expCsr;
        vChkCsr[nVec-1] = 1'b1;
    endtask

    task automatic buildTable();
        u64 a;
        u64 b;
        u64 opBits;
        addVec("add", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, A0, B0, 0, 64'h2222_2222_2222_2211);
        addVec("sub", SRCA_RS1, SRCB_RS2, ALU_SUB, 0, A0, B0, 0, 64'h0246_8acf_1357_9bcf);
        addVec("xor", SRCA_RS1, SRCB_RS2, ALU_XOR, 0, A0, B0, 0, 64'h1dd9_9dd1_1dd9_9dd1);
        vFlush[nVec-1] = 1'b1;
        addVec("or", SRCA_RS1, SRCB_RS2, ALU_OR, 0, A0, B0, 0, 64'h1ffd_dff9_9ffd_dff1);
        addVec("and", SRCA_RS1, SRCB_RS2, ALU_AND, 0, A0, B0, 0, 64'h0224_4228_8224_4220);
        addVec("sll", SRCA_RS1, SRCB_IMM, ALU_SLL, 0, A0, 0, 4, 64'h2345_6789_abcd_ef00);
        addVec("srl", SRCA_RS1, SRCB_IMM, ALU_SRL, 0, 64'hf000_0000_0000_0010, 0, 4,
               64'h0f00_0000_0000_0001);
        addVec("sra", SRCA_RS1, SRCB_IMM, ALU_SRA, 0, 64'hf000_0000_0000_0010, 0, 4,
               64'hff00_0000_0000_0001);
        addVec("slt", SRCA_RS1, SRCB_RS2, ALU_SLT, 0, AllOnes, 1, 0, 64'd1);
        addVec("sltu", SRCA_RS1, SRCB_RS2, ALU_SLTU, 0, AllOnes, 1, 0, 64'd0);
        addVec("lui", SRCA_ZERO, SRCB_IMMUPPER, ALU_ADD, 0, 0, 0, 64'h1_2345, 64'h1234_5000);
        addVec("luiNeg", SRCA_ZERO, SRCB_IMMUPPER, ALU_ADD, 0, 0, 0, 64'hffff_ffff_ffff_fabc,
               64'hffff_ffff_ffab_c000);
        addVec("auipc", SRCA_PC, SRCB_IMMUPPER, ALU_ADD, 0, 0, 0, 1, 64'h8000_2000);
        addVec("link", SRCA_PCPLUS4, SRCB_IMM, ALU_ADD, 0, 0, 0, 0, 64'h8000_1004);
        addVec("pcRs2", SRCA_PC, SRCB_RS2, ALU_ADD, 0, 0, 64'h10, 0, 64'h8000_1010);
        addVec("csrRead", SRCA_ZERO, SRCB_CSR, ALU_ADD, 0, 0, 0, 0, CsrInit);
        addVec("orCsr", SRCA_RS1, SRCB_CSR, ALU_OR, 0, 64'h0f00, 0, 0, 64'hf0f0_0fea);
        addVec("addw", SRCA_RS1, SRCB_RS2, ALU_ADD, 1, 64'h7fff_ffff, 1, 0,
               64'hffff_ffff_8000_0000);
        addVec("subw", SRCA_RS1, SRCB_RS2, ALU_SUB, 1, 64'h1234_5678_0000_0003, 5, 0,
               64'hffff_ffff_ffff_fffe);
        addVec("sllw", SRCA_RS1, SRCB_IMM, ALU_SLL, 1, 3, 0, 64'h3f, 64'hffff_ffff_8000_0000);
        addVec("srlw", SRCA_RS1, SRCB_IMM, ALU_SRL, 1, 64'hffff_ffff_8000_0000, 0, 4,
               64'h0800_0000);
        addVec("sraw", SRCA_RS1, SRCB_IMM, ALU_SRA, 1, 64'hffff_ffff_8000_0000, 0, 4,
               64'hffff_ffff_f800_0000);
        addVec("addiw", SRCA_RS1, SRCB_IMM, ALU_ADD, 1, AllOnes, 0, 1, 64'd0);
        addVec("mulw", SRCA_RS1, SRCB_RS2, ALU_ADD, 1, 64'h1_0000, 64'h8000, 0,
               64'hffff_ffff_8000_0000);
        setMul(MD_MUL);
        // set-on-condition, with operands of mixed sign.
        addVec("sltReg", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 64'hffff_ffff_ffff_fffb, 3, 0, 1);
        setCond(FLAG_LT, 0, 0, 1, 1);
        addVec("sltuReg", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 64'hffff_ffff_ffff_fffb, 3, 0, 0);
        setCond(FLAG_LTU, 0, 0, 1, 0);
        addVec("sgeImm", SRCA_RS1, SRCB_IMM, ALU_ADD, 0, 3, 0, 64'hffff_ffff_ffff_fffb, 1);
        setCond(FLAG_LT, 1, 1, 1, 1);
        addVec("sltuImm", SRCA_RS1, SRCB_IMM, ALU_ADD, 0, 3, 0, 64'hffff_ffff_ffff_fffb, 1);
        setCond(FLAG_LTU, 0, 1, 1, 1);
        addVec("sneReg", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 64'h55, 64'h55, 0, 0);
        setCond(FLAG_EQ, 1, 0, 1, 0);
        addVec("seqImm", SRCA_RS1, SRCB_IMM, ALU_ADD, 0, 7, 0, 8, 0);
        setCond(FLAG_EQ, 0, 1, 1, 0);
        addVec("bne", SRCA_PC, SRCB_IMM, ALU_ADD, 0, 1, 2, 64'h20, 64'h8000_1020);
        setCond(FLAG_EQ, 1, 0, 0, 1);
        addVec("csrrw", SRCA_ZERO, SRCB_CSR, ALU_ADD, 0, 64'h0f0f_ff00, 0, 0, CsrInit);
        setCsr(CSRRW, 64'h0f0f_ff00);
        addVec("csrrs", SRCA_ZERO, SRCB_CSR, ALU_ADD, 0, 64'h0f0f_ff00, 0, 0, CsrInit);
        setCsr(CSRRS, 64'hffff_ffea);
        addVec("csrrc", SRCA_ZERO, SRCB_CSR, ALU_ADD, 0, 64'hf000_000f, 0, 0, CsrInit);
        setCsr(CSRRC, 64'h00f0_00e0);
        addVec("csrrwi", SRCA_ZERO, SRCB_CSR, ALU_ADD, 0, 0, 0, 64'h15, CsrInit);
        setCsr(CSRRWI, 64'h15);
        addVec("csrrsi", SRCA_ZERO, SRCB_CSR, ALU_ADD, 0, 0, 0, 64'h15, CsrInit);
        setCsr(CSRRSI, 64'hf0f0_00ff);
        addVec("csrrci", SRCA_ZERO, SRCB_CSR, ALU_ADD, 0, 0, 0, 64'h0a, CsrInit);
        setCsr(CSRRCI, 64'hf0f0_00e0);
        addVec("mul", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 64'hffff_ffff_ffff_fffd, 7, 0,
               64'hffff_ffff_ffff_ffeb);
        setMul(MD_MUL);
        addVec("mulhNegNeg", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 64'hffff_ffff_ffff_fffe,
               MinInt, 0, 64'd1);
        setMul(MD_MULH);
        addVec("mulhNegPos", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 64'hffff_ffff_ffff_fffd, 7, 0,
               AllOnes);
        setMul(MD_MULH);
        addVec("mulhsu", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, AllOnes, 2, 0, AllOnes);
        setMul(MD_MULHSU);
        addVec("mulhu", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, AllOnes, AllOnes, 0,
               64'hffff_ffff_ffff_fffe);
        setMul(MD_MULHU);
        addVec("div", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, Neg7, 2, 0, 64'hffff_ffff_ffff_fffd);
        setMul(MD_DIV);
        addVec("divZero", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 5, 0, 0, AllOnes);
        setMul(MD_DIV);
        vFlush[nVec-1] = 1'b1;
        addVec("divOverflow", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, MinInt, AllOnes, 0, MinInt);
        setMul(MD_DIV);
        addVec("divu", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, AllOnes, 2, 0, 64'h7fff_ffff_ffff_ffff);
        setMul(MD_DIVU);
        addVec("divuZero", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 9, 0, 0, AllOnes);
        setMul(MD_DIVU);
        addVec("rem", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, Neg7, 2, 0, AllOnes);
        setMul(MD_REM);
        addVec("remZero", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, Neg7, 0, 0, Neg7);
        setMul(MD_REM);
        addVec("remOverflow", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, MinInt, AllOnes, 0, 64'd0);
        setMul(MD_REM);
        addVec("remu", SRCA_RS1, SRCB_RS2, ALU_ADD, 0, 100, 7, 0, 64'd2);
        setMul(MD_REMU);
        // a narrower divisor on odd entries keeps the quotients away from zero.
        for (int k = 0; k < NumRandom; k++) begin
            randomBits(64, a);
            randomBits(64, b);
            randomBits(3, opBits);
            if (k % 2 == 1) begin
                b = b >> 33;
            end
            addVec($sformatf("rand%0d", k), SRCA_RS1, SRCB_RS2, ALU_ADD, 0, a, b, 0,
                   mulDivModel(mulOp_t'(opBits[2:0]), a, b));
            setMul(mulOp_t'(opBits[2:0]));
        end
    endtask

    initial begin
        buildTable();
        repeat (16 + nVec * (XLEN + 8)) @(posedge clk);
        $display("timeout: the vectors did not complete in the expected number of cycles");
        $display("checks: %0d errors: %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

    initial begin
        int    lowCycles;
        u64    fwdSnap;
        string name;
        rst = 1'b1;
        inValid = 1'b0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        pc = PcValue;
        pcPlus4 = PcValue + 4;
        csrValue = CsrInit;
        srcA = SRCA_ZERO;
        srcB = SRCB_RS2;
        aluOp = ALU_ADD;
        isMul = 1'b0;
        mulOp = MD_MUL;
        isWord = 1'b0;
        isCond = 1'b0;
        useFlag = FLAG_LT;
        flagInv = 1'b0;
        cmpUseImm = 1'b0;
        csrOp = CSR_NONE;
        rd = '0;
        writeBack = 1'b0;
        flush = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check("reset outValid", 64'd0, {63'b0, outValid});
        check("reset outWriteBack", 64'd0, {63'b0, outWriteBack});

        for (int n = 0; n < nVec; n++) begin
            name = vName[n];
            inValid = 1'b1;
            rs1 = vRs1[n];
            rs2 = vRs2[n];
            imm = vImm[n];
            srcA = vSrcA[n];
            srcB = vSrcB[n];
            aluOp = vAluOp[n];
            isMul = vIsMul[n];
            mulOp = vMulOp[n];
            isWord = vIsWord[n];
            isCond = vIsCond[n];
            useFlag = vFlagSel[n];
            flagInv = vFlagInv[n];
            cmpUseImm = vCmpImm[n];
            csrOp = vCsrOp[n];
            rd = u5'(n);
            writeBack = n[0];
            flush = vFlush[n];
            #1;
            check({name, " fwdValid"}, {63'b0, rd != 0}, {63'b0, fwdValid});
            check({name, " fwdRd"}, n % 32, {59'b0, fwdRd});
            lowCycles = 0;
            while (!stageReady) begin
                @(posedge clk);
                #2;
                lowCycles++;
            end
            check({name, " stall"}, vIsMul[n] ? XLEN + 1 : 0, lowCycles);
            fwdSnap = fwdData;
            @(posedge clk);
            #1;
            check({name, " result"}, vExpResult[n], outResult);
            check({name, " fwdData"}, vExpResult[n], fwdSnap);
            check({name, " outValid"}, {63'b0, !vFlush[n]}, {63'b0, outValid});
            check({name, " outWriteBack"}, {63'b0, n[0]}, {63'b0, outWriteBack});
            check({name, " outRd"}, n % 32, {59'b0, outRd});
            if (vExpFlag[n] >= 0) begin
                check({name, " flag"}, vExpFlag[n], {63'b0, outFlag});
            end
            if (vChkCsr[n]) begin
                check({name, " csr"}, vExpCsr[n], outCsrValue);
            end
        end
        inValid = 1'b0;
        flush = 1'b0;
        @(posedge clk);
        #1;

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* all.f */
hw/rvPkg.sv
hw/alu.sv
hw/mulDivPrep.sv
hw/mulDivCore.sv
hw/execute.sv
tests/tbExecute.sv

/* Bender.yml */
package:
  name: rv64_execute

sources:
  - files:
      - hw/rvPkg.sv
      - hw/alu.sv
      - hw/mulDivPrep.sv
      - hw/mulDivCore.sv
      - hw/execute.sv
  - target: test
    files:
      - tests/tbExecute.sv
